// File: addr_check.sv
`timescale 1ns/10ps

module addr_check
    import mem_pkg::*;
#(
    parameter word_t dm_end    = 32'h0000_2FFF,
    parameter word_t tc1_begin = 32'h0000_7F00,
    parameter word_t tc1_end   = 32'h0000_7F0B,
    parameter word_t tc2_begin = 32'h0000_7F10,
    parameter word_t tc2_end   = 32'h0000_7F1B,
    parameter word_t int_begin = 32'h0000_7F20,
    parameter word_t int_end   = 32'h0000_7F23
) (
    input  load_op_t  load_op,
    input  store_op_t store_op,
    input  word_t     addr,
    input  exc_code_t exc_in,
    output exc_code_t exc_code
);

    // Timer count registers sit one word at begin + 8
    localparam word_t tc1_count = tc1_begin + 32'd8;
    localparam word_t tc2_count = tc2_begin + 32'd8;

    logic in_dm;
    logic in_tc1;
    logic in_tc2;
    logic in_int;
    logic err_range;
    logic err_align_l;
    logic err_align_s;
    logic err_timer_l;
    logic err_timer_s;
    logic err_count_s;
    logic adel;
    logic ades;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    assign in_dm     = addr <= dm_end;
    assign in_tc1    = addr >= tc1_begin && addr <= tc1_end;
    assign in_tc2    = addr >= tc2_begin && addr <= tc2_end;
    assign in_int    = addr >= int_begin && addr <= int_end;
    assign err_range = !(in_dm || in_tc1 || in_tc2 || in_int);

    //////////////////////////////////////////////////
    // Fault rules
    //////////////////////////////////////////////////

    assign err_align_l = (load_op == load_lw && addr[1:0] != 2'b00) ||
                         ((load_op == load_lh || load_op == load_lhu) && addr[0]);
    assign err_align_s = (store_op == store_sw && addr[1:0] != 2'b00) ||
                         (store_op == store_sh && addr[0]);

    // Peripherals only take full words
    assign err_timer_l = (load_op inside {load_lh, load_lhu, load_lb, load_lbu}) &&
                         addr >= tc1_begin;
    assign err_timer_s = (store_op == store_sh || store_op == store_sb) && addr >= tc1_begin;

    assign err_count_s = (addr >= tc1_count && addr <= tc1_count + 32'd3) ||
                         (addr >= tc2_count && addr <= tc2_count + 32'd3);

    assign adel = (load_op != load_none) && (err_align_l || err_range || err_timer_l);
    assign ades = (store_op != store_none) &&
                  (err_align_s || err_range || err_timer_s || err_count_s);

    // Earlier stage code wins
    always_comb begin
        if (exc_in != exc_none) begin
            exc_code = exc_in;
        end else if (adel) begin
            exc_code = exc_adel;
        end else if (ades) begin
            exc_code = exc_ades;
        end else begin
            exc_code = exc_none;
        end
    end

    // Upstream decode never issues a load and a store together
    always_comb begin
        assert (load_op == load_none || store_op == store_none);
    end

endmodule

// File: cp0_regs.sv
`timescale 1ns/10ps

module cp0_regs
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     pc,
    input  logic      in_bd,
    input  exc_code_t exc_code,
    input  hw_int_t   hw_int,
    input  logic      mtc0,
    input  logic      eret,
    input  reg_addr_t cp0_addr,
    input  word_t     store_data,
    output logic      req,
    output word_t     epc,
    output word_t     cp0_rdata
);

    exl_state_t exl_state;
    exl_state_t exl_next;

    // SR fields
    logic    ie;
    hw_int_t im;

    // Cause fields
    logic      cause_bd;
    hw_int_t   cause_ip;
    exc_code_t cause_code;

    logic  int_req;
    logic  exc_req;
    word_t sr;
    word_t cause;

    //////////////////////////////////////////////////
    // Request generation
    //////////////////////////////////////////////////

    assign int_req = ie && |(hw_int & im);
    assign exc_req = exc_code != exc_none;
    assign req     = (exl_state == exl_run) && (int_req || exc_req);

    //////////////////////////////////////////////////
    // Exception level FSM
    //////////////////////////////////////////////////

    always_comb begin
        exl_next = exl_state;
        case (exl_state)
            exl_run: begin
                if (req) begin
                    exl_next = exl_handler;
                end
            end
            exl_handler: begin
                if (eret) begin
                    exl_next = exl_run;
                end
            end
            default: begin
                exl_next = exl_run;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl_state  <= exl_run;
            ie         <= 1'b0;
            im         <= '0;
            cause_bd   <= 1'b0;
            cause_ip   <= '0;
            cause_code <= exc_none;
            epc        <= '0;
        end else begin
            exl_state <= exl_next;
            cause_ip  <= hw_int;
            if (req) begin
                // Interrupt takes precedence over a pending exception
                epc        <= in_bd ? pc - 32'd4 : pc;
                cause_bd   <= in_bd;
                cause_code <= int_req ? exc_int : exc_code;
            end else if (mtc0) begin
                case (cp0_addr)
                    cp0_sr: begin
                        ie <= store_data[0];
                        im <= store_data[15:10];
                    end
                    cp0_epc: begin
                        epc <= store_data;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Register views with EXL mirroring the FSM
    assign sr    = {16'h0000, im, 8'h00, exl_state == exl_handler, ie};
    assign cause = {cause_bd, 15'h0000, cause_ip, 3'b000, cause_code, 2'b00};

    always_comb begin
        case (cp0_addr)
            cp0_sr:    cp0_rdata = sr;
            cp0_cause: cp0_rdata = cause;
            cp0_epc:   cp0_rdata = epc;
            default:   cp0_rdata = '0;
        endcase
    end

    // Software issues eret only from the handler
    assert property (@(posedge clk) disable iff (reset) eret |-> exl_state == exl_handler);

endmodule

// File: filelist.f
mem_pkg.sv
store_align.sv
load_extend.sv
addr_check.sv
cp0_regs.sv
mem_stage.sv
tb_mem_stage.sv

// File: load_extend.sv
`timescale 1ns/10ps

module load_extend
    import mem_pkg::*;
(
    input  load_op_t   load_op,
    input  logic [1:0] addr_low,
    input  word_t      bus_rdata,
    output word_t      load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Byte lane and halfword picked by the low address bits
    assign sel_byte = bus_rdata[{addr_low, 3'b000} +: 8];
    assign sel_half = addr_low[1] ? bus_rdata[31:16] : bus_rdata[15:0];

    always_comb begin
        case (load_op)
            load_lw: begin
                load_data = bus_rdata;
            end
            load_lh: begin
                load_data = {{16{sel_half[15]}}, sel_half};
            end
            load_lhu: begin
                load_data = {16'h0000, sel_half};
            end
            load_lb: begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            load_lbu: begin
                load_data = {24'h00_0000, sel_byte};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// File: mem_golden.txt
// pc in_bd exc_in load_op store_op addr store_data mtc0 eret cp0_addr hw_int bus_rdata
// then expected: bus_wdata bus_byteen load_data req cp0_rdata epc
// Stores
00003000 0 00 0 1 00000100 12345678 0 0 00 00 00000000 12345678 f 00000000 0 00000000 00000000
00003004 0 00 0 2 00000100 0000abcd 0 0 00 00 00000000 abcdabcd 3 00000000 0 00000000 00000000
00003008 0 00 0 2 00000102 1111abcd 0 0 00 00 00000000 abcdabcd c 00000000 0 00000000 00000000
0000300c 0 00 0 3 00000104 000000e5 0 0 00 00 00000000 e5e5e5e5 1 00000000 0 00000000 00000000
00003010 0 00 0 3 00000105 123456e5 0 0 00 00 00000000 e5e5e5e5 2 00000000 0 00000000 00000000
00003014 0 00 0 3 00000106 000000e5 0 0 00 00 00000000 e5e5e5e5 4 00000000 0 00000000 00000000
00003018 0 00 0 3 00000107 000000e5 0 0 00 00 00000000 e5e5e5e5 8 00000000 0 00000000 00000000
// Loads
0000301c 0 00 1 0 00000200 00000000 0 0 00 00 8091a2b3 00000000 0 8091a2b3 0 00000000 00000000
00003020 0 00 2 0 00000200 00000000 0 0 00 00 8091a2b3 00000000 0 ffffa2b3 0 00000000 00000000
00003024 0 00 2 0 00000202 00000000 0 0 00 00 8091a2b3 00000000 0 ffff8091 0 00000000 00000000
00003028 0 00 3 0 00000202 00000000 0 0 00 00 8091a2b3 00000000 0 00008091 0 00000000 00000000
0000302c 0 00 4 0 00000201 00000000 0 0 00 00 8091a2b3 00000000 0 ffffffa2 0 00000000 00000000
00003030 0 00 5 0 00000203 00000000 0 0 00 00 8091a2b3 00000000 0 00000080 0 00000000 00000000
00003034 0 00 5 0 00000200 00000000 0 0 00 00 8091a2b3 00000000 0 000000b3 0 00000000 00000000
00003038 0 00 4 0 00000202 00000000 0 0 00 00 8091a2b3 00000000 0 ffffff91 0 00000000 00000000
0000303c 0 00 1 0 00007f08 00000000 0 0 00 00 00000042 00000000 0 00000042 0 00000000 00000000
// Address faults, each followed by a Cause read and eret
00003040 0 00 1 0 00000102 00000000 0 0 00 00 00000000 00000000 0 00000000 1 00000000 00000000
00003044 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00000010 00003040
00003050 0 00 0 1 00007f08 00000005 0 0 00 00 00000000 00000005 0 00000000 1 00000000 00003040
00003054 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00000014 00003050
00003060 0 00 0 1 00004000 00000000 0 0 00 00 00000000 00000000 0 00000000 1 00000000 00003050
00003064 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00000014 00003060
00003070 0 00 0 3 00007f11 000000aa 0 0 00 00 00000000 aaaaaaaa 0 00000000 1 00000000 00003060
00003074 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00000014 00003070
00003080 0 00 1 0 00003000 00000000 0 0 00 00 00000000 00000000 0 00000000 1 00000000 00003070
00003084 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00000010 00003080
00003090 0 0c 0 1 00000100 00000001 0 0 00 00 00000000 00000001 0 00000000 1 00000000 00003080
00003094 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00000030 00003090
// Interrupts
00003098 0 00 0 0 00000000 0000fc01 1 0 0c 00 00000000 0000fc01 0 00000000 0 00000000 00003090
0000309c 0 00 0 0 00000000 00000000 0 0 0c 00 00000000 00000000 0 00000000 0 0000fc01 00003090
000030a0 0 00 0 0 00000000 00000000 0 0 0c 04 00000000 00000000 0 00000000 1 0000fc01 00003090
000030a4 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 00001000 000030a0
000030b0 1 00 0 0 00000000 00000000 0 0 0e 01 00000000 00000000 0 00000000 1 000030a0 000030a0
000030b4 0 00 0 0 00000000 00000000 0 1 0d 00 00000000 00000000 0 00000000 0 80000400 000030ac
// Exception level
000030c0 0 00 1 0 00000001 00000000 0 0 00 00 00000000 00000000 0 00000000 1 00000000 000030ac
000030d0 0 00 1 0 00000002 00000000 0 0 0c 00 00000000 00000000 0 00000000 0 0000fc03 000030c0
000030d4 0 00 0 0 00000000 00000000 0 1 0c 00 00000000 00000000 0 00000000 0 0000fc03 000030c0
000030d8 0 00 0 0 00000000 00000000 0 0 0c 00 00000000 00000000 0 00000000 0 0000fc01 000030c0
000030dc 0 00 0 0 00000000 00001234 1 0 0e 00 00000000 00001234 0 00000000 0 000030c0 000030c0
000030e0 0 00 0 0 00000000 00000000 0 0 0e 00 00000000 00000000 0 00000000 0 00001234 00001234
// End marker
ffffffff

// File: mem_pkg.sv
package mem_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  hw_int_t;

    //////////////////////////////////////////////////
    // Memory operations
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        store_none,
        store_sw,
        store_sh,
        store_sb
    } store_op_t;

    typedef enum logic [2:0] {
        load_none,
        load_lw,
        load_lh,
        load_lhu,
        load_lb,
        load_lbu
    } load_op_t;

    //////////////////////////////////////////////////
    // Exceptions and CP0
    //////////////////////////////////////////////////

    typedef enum logic [4:0] {
        exc_none    = 5'd0,
        exc_adel    = 5'd4,
        exc_ades    = 5'd5,
        exc_syscall = 5'd8,
        exc_ri      = 5'd10,
        exc_ov      = 5'd12
    } exc_code_t;

    // Interrupt code shares zero with exc_none and only goes into Cause
    localparam exc_code_t exc_int = exc_none;

    typedef enum logic {
        exl_run,
        exl_handler
    } exl_state_t;

    localparam reg_addr_t cp0_sr    = 5'd12;
    localparam reg_addr_t cp0_cause = 5'd13;
    localparam reg_addr_t cp0_epc   = 5'd14;

endpackage

// File: mem_stage.sv
`timescale 1ns/10ps

module mem_stage
    import mem_pkg::*;
#(
    parameter word_t dm_end    = 32'h0000_2FFF,
    parameter word_t tc1_begin = 32'h0000_7F00,
    parameter word_t tc1_end   = 32'h0000_7F0B,
    parameter word_t tc2_begin = 32'h0000_7F10,
    parameter word_t tc2_end   = 32'h0000_7F1B,
    parameter word_t int_begin = 32'h0000_7F20,
    parameter word_t int_end   = 32'h0000_7F23
) (
    input  logic      clk,
    input  logic      reset,
    input  word_t     pc,
    input  logic      in_bd,
    input  exc_code_t exc_in,
    input  load_op_t  load_op,
    input  store_op_t store_op,
    input  word_t     addr,
    input  word_t     store_data,
    input  logic      mtc0,
    input  logic      eret,
    input  reg_addr_t cp0_addr,
    input  hw_int_t   hw_int,
    input  word_t     bus_rdata,
    output word_t     bus_addr,
    output word_t     bus_wdata,
    output byteen_t   bus_byteen,
    output word_t     load_data,
    output word_t     cp0_rdata,
    output word_t     epc,
    output logic      req
);

    exc_code_t exc_code;

    assign bus_addr = addr;

    //////////////////////////////////////////////////
    // Access checks and CP0
    //////////////////////////////////////////////////

    addr_check #(
        .dm_end    (dm_end),
        .tc1_begin (tc1_begin),
        .tc1_end   (tc1_end),
        .tc2_begin (tc2_begin),
        .tc2_end   (tc2_end),
        .int_begin (int_begin),
        .int_end   (int_end)
    ) i_addr_check (
        .load_op  (load_op),
        .store_op (store_op),
        .addr     (addr),
        .exc_in   (exc_in),
        .exc_code (exc_code)
    );

    cp0_regs i_cp0_regs (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .in_bd      (in_bd),
        .exc_code   (exc_code),
        .hw_int     (hw_int),
        .mtc0       (mtc0),
        .eret       (eret),
        .cp0_addr   (cp0_addr),
        .store_data (store_data),
        .req        (req),
        .epc        (epc),
        .cp0_rdata  (cp0_rdata)
    );

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    store_align i_store_align (
        .store_op   (store_op),
        .addr       (addr),
        .store_data (store_data),
        .req        (req),
        .bus_wdata  (bus_wdata),
        .bus_byteen (bus_byteen)
    );

    load_extend i_load_extend (
        .load_op   (load_op),
        .addr_low  (addr[1:0]),
        .bus_rdata (bus_rdata),
        .load_data (load_data)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the mem_stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f filelist.f --top-module tb_mem_stage -o sim_mem_stage &&
./obj_dir/sim_mem_stage | tee /dev/stderr | grep -qx "test passed" &&
exit 0 || exit 1

// File: store_align.sv
`timescale 1ns/10ps

module store_align
    import mem_pkg::*;
(
    input  store_op_t store_op,
    input  word_t     addr,
    input  word_t     store_data,
    input  logic      req,
    output word_t     bus_wdata,
    output byteen_t   bus_byteen
);

    byteen_t lanes;

    // Lane select and data replication
    always_comb begin
        lanes     = '0;
        bus_wdata = store_data;
        case (store_op)
            store_sw: begin
                lanes = 4'b1111;
            end
            store_sh: begin
                lanes     = addr[1] ? 4'b1100 : 4'b0011;
                bus_wdata = {2{store_data[15:0]}};
            end
            store_sb: begin
                lanes     = 4'b0001 << addr[1:0];
                bus_wdata = {4{store_data[7:0]}};
            end
            default: begin
                lanes = '0;
            end
        endcase
    end

    // Taken exception squashes the write
    assign bus_byteen = req ? '0 : lanes;

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage
    import mem_pkg::*;
();

    // Tokens per golden line with inputs first and expected outputs after
    localparam int fields    = 18;
    localparam int max_lines = 64;
    localparam word_t end_marker = 32'hffff_ffff;

    logic      clk;
    logic      reset;
    word_t     pc;
    logic      in_bd;
    exc_code_t exc_in;
    load_op_t  load_op;
    store_op_t store_op;
    word_t     addr;
    word_t     store_data;
    logic      mtc0;
    logic      eret;
    reg_addr_t cp0_addr;
    hw_int_t   hw_int;
    word_t     bus_rdata;

    word_t   bus_addr;
    word_t   bus_wdata;
    byteen_t bus_byteen;
    word_t   load_data;
    word_t   cp0_rdata;
    word_t   epc;
    logic    req;

    word_t golden [0:fields*max_lines-1];
    int    n_lines;
    int    cycles;
    int    cycle_limit = max_lines + 10;

    mem_stage i_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .in_bd      (in_bd),
        .exc_in     (exc_in),
        .load_op    (load_op),
        .store_op   (store_op),
        .addr       (addr),
        .store_data (store_data),
        .mtc0       (mtc0),
        .eret       (eret),
        .cp0_addr   (cp0_addr),
        .hw_int     (hw_int),
        .bus_rdata  (bus_rdata),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_byteen (bus_byteen),
        .load_data  (load_data),
        .cp0_rdata  (cp0_rdata),
        .epc        (epc),
        .req        (req)
    );

    //////////////////////////////////////////////////
    // Clock and timeout
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout after %0d cycles, the run hung", cycles);
                $display("test failed");
                $fatal(1, "timeout");
            end
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_byteen(input string name, input byteen_t expected,
                                input byteen_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "byte enable mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Golden vectors
    //////////////////////////////////////////////////

    // Vectors end at a line whose pc is the marker
    function automatic int count_lines();
        int n;
        n = 0;
        while (n < max_lines && golden[n*fields] != end_marker) begin
            n++;
        end
        if (n == max_lines) begin
            n = 0;
        end
        return n;
    endfunction

    task automatic apply_vector(input int line);
        int b;
        b = line * fields;
        pc         <= golden[b];
        in_bd      <= golden[b+1][0];
        exc_in     <= exc_code_t'(golden[b+2][4:0]);
        load_op    <= load_op_t'(golden[b+3][2:0]);
        store_op   <= store_op_t'(golden[b+4][1:0]);
        addr       <= golden[b+5];
        store_data <= golden[b+6];
        mtc0       <= golden[b+7][0];
        eret       <= golden[b+8][0];
        cp0_addr   <= golden[b+9][4:0];
        hw_int     <= golden[b+10][5:0];
        bus_rdata  <= golden[b+11];
    endtask

    task automatic check_outputs(input int line);
        int    b;
        string tag;
        b   = line * fields;
        tag = $sformatf("line %0d", line + 1);
        check_word({tag, " bus_addr"}, addr, bus_addr);
        check_word({tag, " bus_wdata"}, golden[b+12], bus_wdata);
        check_byteen({tag, " bus_byteen"}, golden[b+13][3:0], bus_byteen);
        check_word({tag, " load_data"}, golden[b+14], load_data);
        check_flag({tag, " req"}, golden[b+15][0], req);
        check_word({tag, " cp0_rdata"}, golden[b+16], cp0_rdata);
        check_word({tag, " epc"}, golden[b+17], epc);
    endtask

    initial begin
        reset      = 1'b1;
        pc         = '0;
        in_bd      = 1'b0;
        exc_in     = exc_none;
        load_op    = load_none;
        store_op   = store_none;
        addr       = '0;
        store_data = '0;
        mtc0       = 1'b0;
        eret       = 1'b0;
        cp0_addr   = '0;
        hw_int     = '0;
        bus_rdata  = '0;

        $readmemh("mem_golden.txt", golden);
        n_lines = count_lines();

        if (n_lines == 0) begin
            $display("Golden file has no vectors or no end marker");
            $display("test failed");
            $fatal(1, "no vectors");
        end else begin
            cycle_limit = n_lines + 10;
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            for (int line = 0; line < n_lines; line++) begin
                @(posedge clk);
                apply_vector(line);
                // Outputs settle well before the falling edge
                @(negedge clk);
                check_outputs(line);
            end
            $display("test passed");
            $finish;
        end
    end

endmodule
